// ==== src/clock_bus_pkg.sv ====
package clock_bus_pkg;

    // wishbone classic, host side
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [1:0]  adr;  // word address, 4 regs
        logic [31:0] dat;  // write data
    } wb_req_t;

    // slave side
    typedef struct packed {
        logic        ack;  // single cycle
        logic [31:0] dat;  // read data, valid with ack
    } wb_rsp_t;

    // register map
    localparam logic [1:0] ADDR_TIME = 2'd0;  // hh:mm:ss in [16:0]
    localparam logic [1:0] ADDR_DATE = 2'd1;  // dd/mo/yy in [15:0]
    localparam logic [1:0] ADDR_CTRL = 2'd2;
    localparam logic [1:0] ADDR_ADJ  = 2'd3;  // write only

    // bit positions
    localparam int CTRL_RUN_BIT  = 0;
    localparam int CTRL_SHOW_BIT = 1;
    localparam int ADJ_DOWN_BIT  = 3;  // field select in [2:0]

endpackage

// ==== src/calendar_pkg.sv ====
package calendar_pkg;

    typedef struct packed {
        logic [4:0] hour;  // 0..23
        logic [5:0] min;   // 0..59
        logic [5:0] sec;   // 0..59
    } time_t;

    typedef struct packed {
        logic [4:0] day;    // 1..31
        logic [3:0] month;  // 1..12
        logic [6:0] year;   // 0..99, means 2000..2099
    } date_t;

    typedef enum logic [2:0] {
        FLD_SEC,
        FLD_MIN,
        FLD_HOUR,
        FLD_DAY,
        FLD_MONTH,
        FLD_YEAR
    } field_e;

    typedef struct packed {
        logic   valid;
        field_e field;
        logic   down;  // 0 steps up
    } adjust_t;

    typedef struct packed {
        logic  valid;
        time_t value;
    } time_load_t;

    typedef struct packed {
        logic  valid;
        date_t value;
    } date_load_t;

    // 2000..2099 only, so every fourth year is a leap year
    function automatic logic [4:0] days_in_month(input logic [3:0] month,
                                                 input logic [6:0] year);
        case (month)
            4'd2:                      return (year[1:0] == 2'b00) ? 5'd29 : 5'd28;
            4'd4, 4'd6, 4'd9, 4'd11:   return 5'd30;
            default:                   return 5'd31;  // includes bad month codes
        endcase
    endfunction

    // one step within lo..hi, wraps both ways
    function automatic logic [6:0] step_field(input logic [6:0] val,
                                              input logic [6:0] lo,
                                              input logic [6:0] hi,
                                              input logic       down);
        if (down) begin
            return (val <= lo) ? hi : val - 7'd1;
        end
        return (val >= hi) ? lo : val + 7'd1;  // also pulls stray values back in
    endfunction

endpackage

// ==== src/wb_reg_slave.sv ====
`timescale 1ns/1ns

module wb_reg_slave (
    input  logic                       clk,
    input  logic                       rst,
    input  clock_bus_pkg::wb_req_t     wb_i,
    output clock_bus_pkg::wb_rsp_t     wb_o,
    input  calendar_pkg::time_t        cur_time,
    input  calendar_pkg::date_t        cur_date,
    output calendar_pkg::time_load_t   time_load,
    output calendar_pkg::date_load_t   date_load,
    output calendar_pkg::adjust_t      adj,
    output logic                       run,
    output logic                       show_date
);

    logic        ack_q;
    logic [31:0] rdat_q;
    logic [31:0] rdat;
    logic        req;  // cycle open and not acked yet
    logic        wr;

    assign req = wb_i.cyc & wb_i.stb & ~ack_q;
    assign wr  = req & wb_i.we;

    // ack one cycle after the request is seen, gone the cycle after
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req;
        end
    end

    // ctrl bits, written on the ack-rising edge
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            run       <= 1'b0;
            show_date <= 1'b0;
        end else if (wr && wb_i.adr == clock_bus_pkg::ADDR_CTRL) begin
            run       <= wb_i.dat[clock_bus_pkg::CTRL_RUN_BIT];
            show_date <= wb_i.dat[clock_bus_pkg::CTRL_SHOW_BIT];
        end
    end

    // readback mux
    always_comb begin
        case (wb_i.adr)
            clock_bus_pkg::ADDR_TIME: rdat = {15'd0, cur_time};
            clock_bus_pkg::ADDR_DATE: rdat = {16'd0, cur_date};
            clock_bus_pkg::ADDR_CTRL: rdat = {30'd0, show_date, run};
            default:                  rdat = 32'd0;  // adj is write only
        endcase
    end

    always_ff @(posedge clk) begin
        if (req) rdat_q <= rdat;  // captured alongside ack
    end

    assign wb_o.ack = ack_q;
    assign wb_o.dat = rdat_q;

    // one-cycle command strobes, acted on at the ack edge
    assign time_load.valid = wr && (wb_i.adr == clock_bus_pkg::ADDR_TIME);
    assign time_load.value = wb_i.dat[$bits(calendar_pkg::time_t)-1:0];
    assign date_load.valid = wr && (wb_i.adr == clock_bus_pkg::ADDR_DATE);
    assign date_load.value = wb_i.dat[$bits(calendar_pkg::date_t)-1:0];
    assign adj.valid       = wr && (wb_i.adr == clock_bus_pkg::ADDR_ADJ);
    assign adj.field       = calendar_pkg::field_e'(wb_i.dat[2:0]);
    assign adj.down        = wb_i.dat[clock_bus_pkg::ADJ_DOWN_BIT];

    // host must have asked first
    a_ack_after_req : assert property (@(posedge clk) disable iff (!rst)
        wb_o.ack |-> $past(wb_i.cyc && wb_i.stb));

endmodule

// ==== src/tick_prescaler.sv ====
`timescale 1ns/1ns

module tick_prescaler #(
    parameter int TICKS_PER_SEC = 50_000_000
) (
    input  logic clk,
    input  logic rst,
    input  logic run,
    output logic tick
);

    localparam int CNT_W = (TICKS_PER_SEC > 1) ? $clog2(TICKS_PER_SEC) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(TICKS_PER_SEC - 1);

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            cnt <= '0;
        end else if (!run) begin
            cnt <= '0;  // restart a full second on next run
        end else if (cnt == CNT_LAST) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    assign tick = run && (cnt == CNT_LAST);  // last count of the second

    // count clears while stopped so a tick needs run the cycle before
    a_tick_only_running : assert property (@(posedge clk) disable iff (!rst)
        tick |-> $past(run));

endmodule

// ==== src/time_counter.sv ====
`timescale 1ns/1ns

module time_counter (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      run,
    input  logic                      tick,
    input  calendar_pkg::time_load_t  time_load,
    input  calendar_pkg::adjust_t     adj,
    output calendar_pkg::time_t       cur_time,
    output logic                      day_carry
);

    calendar_pkg::time_t time_q;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            time_q <= '0;  // 00:00:00
        end else if (time_load.valid) begin
            time_q <= time_load.value;  // taken as is
        end else if (tick) begin
            // seconds, carry ripples through in one cycle
            if (time_q.sec == 6'd59) begin
                time_q.sec <= 6'd0;
                if (time_q.min == 6'd59) begin
                    time_q.min  <= 6'd0;
                    time_q.hour <= (time_q.hour == 5'd23) ? 5'd0 : time_q.hour + 5'd1;
                end else begin
                    time_q.min <= time_q.min + 6'd1;
                end
            end else begin
                time_q.sec <= time_q.sec + 6'd1;
            end
        end else if (adj.valid && !run) begin
            // single field, no carry into neighbours
            case (adj.field)
                calendar_pkg::FLD_SEC:
                    time_q.sec  <= 6'(calendar_pkg::step_field(7'(time_q.sec), 7'd0,
                                                                7'd59, adj.down));
                calendar_pkg::FLD_MIN:
                    time_q.min  <= 6'(calendar_pkg::step_field(7'(time_q.min), 7'd0,
                                                                7'd59, adj.down));
                calendar_pkg::FLD_HOUR:
                    time_q.hour <= 5'(calendar_pkg::step_field(7'(time_q.hour), 7'd0,
                                                                7'd23, adj.down));
                default: ;  // date fields, not ours
            endcase
        end
    end

    assign cur_time = time_q;

    // midnight, same cycle as the wrapping tick
    assign day_carry = tick && !time_load.valid && (time_q.hour == 5'd23) &&
                       (time_q.min == 6'd59) && (time_q.sec == 6'd59);

    a_time_in_range : assert property (@(posedge clk) disable iff (!rst)
        !time_load.valid |=> (time_q.hour < 5'd24) && (time_q.min < 6'd60) &&
                             (time_q.sec < 6'd60));

endmodule

// ==== src/date_counter.sv ====
`timescale 1ns/1ns

module date_counter (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      run,
    input  logic                      day_carry,
    input  calendar_pkg::date_load_t  date_load,
    input  calendar_pkg::adjust_t     adj,
    output calendar_pkg::date_t       cur_date
);

    calendar_pkg::date_t date_q;

    logic [4:0] dim;        // length of current month
    logic [3:0] adj_month;  // month after a step
    logic [6:0] adj_year;   // year after a step
    logic [4:0] adj_dim;    // length once the step lands

    assign dim = calendar_pkg::days_in_month(date_q.month, date_q.year);

    assign adj_month = 4'(calendar_pkg::step_field(7'(date_q.month), 7'd1, 7'd12, adj.down));
    assign adj_year  = calendar_pkg::step_field(date_q.year, 7'd0, 7'd99, adj.down);

    // only one of month/year moves per step
    assign adj_dim = calendar_pkg::days_in_month(
        (adj.field == calendar_pkg::FLD_MONTH) ? adj_month : date_q.month,
        (adj.field == calendar_pkg::FLD_YEAR)  ? adj_year  : date_q.year);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            date_q.day   <= 5'd1;  // 01/01/00
            date_q.month <= 4'd1;
            date_q.year  <= 7'd0;
        end else if (date_load.valid) begin
            date_q <= date_load.value;
        end else if (day_carry) begin
            if (date_q.day >= dim) begin
                date_q.day <= 5'd1;
                if (date_q.month >= 4'd12) begin
                    date_q.month <= 4'd1;
                    date_q.year  <= (date_q.year >= 7'd99) ? 7'd0 : date_q.year + 7'd1;
                end else begin
                    date_q.month <= date_q.month + 4'd1;
                end
            end else begin
                date_q.day <= date_q.day + 5'd1;
            end
        end else if (adj.valid && !run) begin
            case (adj.field)
                calendar_pkg::FLD_DAY:
                    date_q.day <= 5'(calendar_pkg::step_field(7'(date_q.day), 7'd1,
                                                               7'(dim), adj.down));
                calendar_pkg::FLD_MONTH: begin
                    date_q.month <= adj_month;
                    if (date_q.day > adj_dim) date_q.day <= adj_dim;  // e.g. 31 -> 29 in feb
                end
                calendar_pkg::FLD_YEAR: begin
                    date_q.year <= adj_year;
                    if (date_q.day > adj_dim) date_q.day <= adj_dim;  // 29/02 into non-leap
                end
                default: ;  // time fields
            endcase
        end
    end

    assign cur_date = date_q;

    // loads are trusted, so only checked once the month is sane
    a_day_in_month : assert property (@(posedge clk) disable iff (!rst)
        (date_q.month >= 4'd1 && date_q.month <= 4'd12 && !$past(date_load.valid))
        |-> (date_q.day >= 5'd1 && date_q.day <= dim));

endmodule

// ==== src/display_encoder.sv ====
`timescale 1ns/1ns

module display_encoder (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 show_date,
    input  calendar_pkg::time_t  cur_time,
    input  calendar_pkg::date_t  cur_date,
    output logic [23:0]          digits
);

    logic [23:0] digits_d;

    // 0..99 to two bcd digits, tens in the upper nibble
    function automatic logic [7:0] to_bcd(input logic [6:0] val);
        logic [6:0] tens;
        logic [6:0] units;
        tens  = val / 7'd10;
        units = val % 7'd10;
        return {tens[3:0], units[3:0]};
    endfunction

    always_comb begin
        if (show_date) begin
            digits_d = {to_bcd(7'(cur_date.day)), to_bcd(7'(cur_date.month)),
                        to_bcd(cur_date.year)};  // dd mo yy
        end else begin
            digits_d = {to_bcd(7'(cur_time.hour)), to_bcd(7'(cur_time.min)),
                        to_bcd(7'(cur_time.sec))};  // hh mm ss
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            digits <= 24'd0;  // blank zeros
        end else begin
            digits <= digits_d;  // one cycle behind the counters
        end
    end

endmodule

// ==== src/calendar_clock_top.sv ====
`timescale 1ns/1ns

module calendar_clock_top #(
    parameter int TICKS_PER_SEC = 50_000_000
) (
    input  logic                    clk,
    input  logic                    rst,
    input  clock_bus_pkg::wb_req_t  wb_i,
    output clock_bus_pkg::wb_rsp_t  wb_o,
    output logic [23:0]             digits
);

    calendar_pkg::time_t       cur_time;
    calendar_pkg::date_t       cur_date;
    calendar_pkg::time_load_t  time_load;
    calendar_pkg::date_load_t  date_load;
    calendar_pkg::adjust_t     adj;
    logic                      run;
    logic                      show_date;
    logic                      tick;
    logic                      day_carry;  // midnight

    wb_reg_slave u_regs (.clk, .rst, .wb_i, .wb_o, .cur_time, .cur_date,
                         .time_load, .date_load, .adj, .run, .show_date);

    tick_prescaler #(.TICKS_PER_SEC(TICKS_PER_SEC)) u_presc (.clk, .rst, .run, .tick);

    time_counter u_time (.clk, .rst, .run, .tick, .time_load, .adj,
                         .cur_time, .day_carry);

    date_counter u_date (.clk, .rst, .run, .day_carry, .date_load, .adj, .cur_date);

    display_encoder u_disp (.clk, .rst, .show_date, .cur_time, .cur_date, .digits);

endmodule

// ==== verif/tb_calendar_clock.sv ====
`timescale 1ns/1ns

module tb_calendar_clock;

    localparam int TICKS     = 4;   // clocks per second in the testbench
    localparam int ACK_LIMIT = 20;  // bus wait bound in clocks

    logic                   clk;
    logic                   rst;
    clock_bus_pkg::wb_req_t wb_i;
    clock_bus_pkg::wb_rsp_t wb_o;
    logic [23:0]            digits;

    integer seed = 32'h3389_e55b;
    int     errors = 0;
    int     checks = 0;
    int     tests = 0;

    calendar_clock_top #(.TICKS_PER_SEC(TICKS)) DUT (.clk, .rst, .wb_i, .wb_o, .digits);

    always #4 clk = ~clk;  // 8 ns period

    // reference model of the calendar rules
    function automatic logic [4:0] month_len(input logic [3:0] m, input logic [6:0] y);
        if (m == 4'd2) return (y % 7'd4 == 7'd0) ? 5'd29 : 5'd28;  // no century rule
        if (m == 4'd4 || m == 4'd6 || m == 4'd9 || m == 4'd11) return 5'd30;
        return 5'd31;
    endfunction

    function automatic calendar_pkg::date_t next_day(input calendar_pkg::date_t d);
        calendar_pkg::date_t n;
        n = d;
        if (d.day < month_len(d.month, d.year)) begin
            n.day = d.day + 5'd1;
        end else begin
            n.day = 5'd1;  // new month
            if (d.month < 4'd12) begin
                n.month = d.month + 4'd1;
            end else begin
                n.month = 4'd1;
                n.year  = (d.year == 7'd99) ? 7'd0 : d.year + 7'd1;  // 2099 -> 2000
            end
        end
        return n;
    endfunction

    function automatic calendar_pkg::time_t make_time(input int h, input int m, input int s);
        calendar_pkg::time_t t;
        t.hour = 5'(h);
        t.min  = 6'(m);
        t.sec  = 6'(s);
        return t;
    endfunction

    function automatic calendar_pkg::date_t make_date(input int d, input int m, input int y);
        calendar_pkg::date_t r;
        r.day   = 5'(d);
        r.month = 4'(m);
        r.year  = 7'(y);
        return r;
    endfunction

    function automatic logic [7:0] two_digits(input int v);
        return {4'(v / 10), 4'(v % 10)};  // tens then units
    endfunction

    // compare tasks
    task automatic check_time(input string name, input calendar_pkg::time_t got,
                              input calendar_pkg::time_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_date(input string name, input calendar_pkg::date_t got,
                              input calendar_pkg::date_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_digits(input logic [23:0] exp);
        checks++;
        if (digits !== exp) begin
            errors++;
            $display("Error at %0t ns: digits is %h, expected %h", $time, digits, exp);
        end
    endtask

    task automatic wait_clocks(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;  // back to the drive point
        end
    endtask

    // one classic cycle, held until ack
    task automatic bus_cycle(input logic we, input logic [1:0] adr, input logic [31:0] dat,
                             output logic [31:0] rd);
        int n;
        wb_i.cyc = 1'b1;
        wb_i.stb = 1'b1;
        wb_i.we  = we;
        wb_i.adr = adr;
        wb_i.dat = dat;
        n = 0;
        do begin
            @(posedge clk);
            #1;
            n++;
        end while (!wb_o.ack && n < ACK_LIMIT);
        rd = wb_o.dat;  // valid while ack is high
        if (!wb_o.ack) begin
            errors++;
            $display("the slave never acknowledged the access to register %0d", adr);
        end
        wb_i = '0;
    endtask

    task automatic wb_write(input logic [1:0] adr, input logic [31:0] dat);
        logic [31:0] unused;
        bus_cycle(1'b1, adr, dat, unused);
    endtask

    task automatic wb_read(input logic [1:0] adr, output logic [31:0] rd);
        bus_cycle(1'b0, adr, 32'd0, rd);
    endtask

    task automatic read_time(output calendar_pkg::time_t t);
        logic [31:0] rd;
        wb_read(clock_bus_pkg::ADDR_TIME, rd);
        t = rd[16:0];
    endtask

    task automatic read_date(output calendar_pkg::date_t d);
        logic [31:0] rd;
        wb_read(clock_bus_pkg::ADDR_DATE, rd);
        d = rd[15:0];
    endtask

    task automatic load(input calendar_pkg::time_t t, input calendar_pkg::date_t d);
        wb_write(clock_bus_pkg::ADDR_TIME, {15'd0, t});
        wb_write(clock_bus_pkg::ADDR_DATE, {16'd0, d});
    endtask

    task automatic adjust(input calendar_pkg::field_e f, input logic down);
        wb_write(clock_bus_pkg::ADDR_ADJ, {28'd0, down, f});
    endtask

    // run exactly n seconds, stop lands before the next tick
    task automatic run_seconds(input int n);
        wb_write(clock_bus_pkg::ADDR_CTRL, 32'd1);
        wait_clocks(TICKS * n);
        wb_write(clock_bus_pkg::ADDR_CTRL, 32'd0);
    endtask

    task automatic report_test(input string name, input int err_before);
        tests++;
        if (errors == err_before) $display("test %0d %s: pass", tests, name);
        else $display("test %0d %s: %0d errors", tests, name, errors - err_before);
    endtask

    task automatic test_reset_and_load();
        calendar_pkg::time_t t;
        calendar_pkg::date_t d;
        calendar_pkg::time_t t_rd;
        calendar_pkg::date_t d_rd;
        logic [31:0]         rd;
        int                  e0;
        e0 = errors;
        read_time(t_rd);
        check_time("TIME", t_rd, make_time(0, 0, 0));
        read_date(d_rd);
        check_date("DATE", d_rd, make_date(1, 1, 0));
        wb_read(clock_bus_pkg::ADDR_CTRL, rd);
        check_word("CTRL", rd, 32'd0);
        repeat (3) begin
            t = make_time($unsigned($random(seed)) % 24, $unsigned($random(seed)) % 60,
                          $unsigned($random(seed)) % 60);
            d.year  = 7'($unsigned($random(seed)) % 100);
            d.month = 4'(1 + $unsigned($random(seed)) % 12);
            d.day   = 5'(1 + $unsigned($random(seed)) % month_len(d.month, d.year));
            load(t, d);
            read_time(t_rd);
            check_time("TIME", t_rd, t);
            read_date(d_rd);
            check_date("DATE", d_rd, d);
        end
        report_test("reset and load", e0);
    endtask

    task automatic test_year_wrap();
        calendar_pkg::time_t t_rd;
        calendar_pkg::date_t d_rd;
        int                  e0;
        e0 = errors;
        load(make_time(23, 59, 58), make_date(31, 12, 99));
        run_seconds(2);
        read_time(t_rd);
        check_time("TIME", t_rd, make_time(0, 0, 0));
        read_date(d_rd);
        check_date("DATE", d_rd, next_day(make_date(31, 12, 99)));
        report_test("year wrap", e0);
    endtask

    task automatic test_leap_years();
        calendar_pkg::date_t d_rd;
        int                  e0;
        e0 = errors;
        load(make_time(23, 59, 59), make_date(28, 2, 24));
        run_seconds(1);
        read_date(d_rd);
        check_date("DATE", d_rd, next_day(make_date(28, 2, 24)));  // leap day
        wb_write(clock_bus_pkg::ADDR_TIME, {15'd0, make_time(23, 59, 59)});
        run_seconds(1);
        read_date(d_rd);
        check_date("DATE", d_rd, next_day(make_date(29, 2, 24)));
        load(make_time(23, 59, 59), make_date(28, 2, 23));
        run_seconds(1);
        read_date(d_rd);
        check_date("DATE", d_rd, next_day(make_date(28, 2, 23)));  // straight to march
        report_test("leap years", e0);
    endtask

    task automatic test_adjust();
        calendar_pkg::time_t t_rd;
        calendar_pkg::date_t d_rd;
        int                  e0;
        e0 = errors;
        load(make_time(10, 59, 30), make_date(1, 4, 24));
        adjust(calendar_pkg::FLD_DAY, 1'b1);
        read_date(d_rd);
        check_date("DATE", d_rd, make_date(month_len(4'd4, 7'd24), 4, 24));
        adjust(calendar_pkg::FLD_MIN, 1'b0);
        read_time(t_rd);
        check_time("TIME", t_rd, make_time(10, 0, 30));  // hour untouched
        wb_write(clock_bus_pkg::ADDR_DATE, {16'd0, make_date(31, 1, 24)});
        adjust(calendar_pkg::FLD_MONTH, 1'b0);
        read_date(d_rd);
        check_date("DATE", d_rd, make_date(month_len(4'd2, 7'd24), 2, 24));  // clamped
        wb_write(clock_bus_pkg::ADDR_CTRL, 32'd1);
        adjust(calendar_pkg::FLD_YEAR, 1'b0);  // should be ignored while running
        wb_write(clock_bus_pkg::ADDR_CTRL, 32'd0);
        read_date(d_rd);
        check_date("DATE", d_rd, make_date(29, 2, 24));
        report_test("adjust", e0);
    endtask

    task automatic test_display();
        int e0;
        e0 = errors;
        wb_write(clock_bus_pkg::ADDR_TIME, {15'd0, make_time(12, 34, 56)});
        wb_write(clock_bus_pkg::ADDR_CTRL, 32'd0);
        wait_clocks(1);
        check_digits({two_digits(12), two_digits(34), two_digits(56)});  // hh mm ss
        wb_write(clock_bus_pkg::ADDR_CTRL, 32'd2);  // show_date only
        wait_clocks(1);
        check_digits({two_digits(29), two_digits(2), two_digits(24)});  // dd mo yy
        report_test("display", e0);
    endtask

    // watchdog for the whole run
    initial begin
        #100_000;
        $display("the simulation ran past its time limit");
        $display("Something failed");
        $finish;
    end

    initial begin
        clk  = 1'b0;
        rst  = 1'b0;
        wb_i = '0;
        repeat (4) @(posedge clk);
        #1 rst = 1'b1;
        test_reset_and_load();
        test_year_wrap();
        test_leap_years();
        test_adjust();
        test_display();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
src/clock_bus_pkg.sv
src/calendar_pkg.sv
src/wb_reg_slave.sv
src/tick_prescaler.sv
src/time_counter.sv
src/date_counter.sv
src/display_encoder.sv
src/calendar_clock_top.sv
verif/tb_calendar_clock.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f filelist.f \
		--top-module tb_calendar_clock -o sim_calendar
	@out="$$(./obj_dir/sim_calendar)"; echo "$$out"; echo "$$out" | grep -qx "Everything OK"

clean:
	rm -rf obj_dir
